//--- filelist.f
+incdir+.
neo_loader_pkg.sv
neo_header_parser.sv
neo_sdram_req_port.sv
neo_dl_fifo.sv
neo_adpcm_fetch.sv
neo_cart_loader.sv
tb_neo_sdram_model.sv
tb_neo_cart_loader.sv

//--- neo_adpcm_fetch.sv
`include "neo_loader_defs.svh"
`default_nettype none

module neo_adpcm_fetch (
	input  wire logic               CLK_48M,
	input  wire logic               pll_locked,
	input  wire logic               rd,
	input  wire logic [23:0]        addr,
	input  wire logic [23:0]        mask,
	input  wire logic [25:0]        base,
	input  wire logic               adpcm_en,
	input  wire logic               ack,
	input  wire logic [31:0]        q,
	output logic                    req,
	output neo_loader_pkg::rd_req_t payload,
	output logic [7:0]              data,
	output logic                    ready
);
	import neo_loader_pkg::*;

	logic        rd_q;
	logic        latch_valid;
	logic [23:0] latch;
	logic [23:0] masked;
	logic [25:0] word_byte;
	logic        rd_rise;
	logic        issue;
	logic        busy;
	rd_req_t     next_req;

	assign rd_rise = rd && !rd_q;
	assign masked  = addr & mask;

	// Same 32-bit word as last time needs no new read
	assign issue = rd_rise && adpcm_en && (!latch_valid || masked[23:2] != latch[23:2]);

	assign word_byte     = base + {2'b00, masked[23:2], 2'b00};
	assign next_req.addr = word_byte[25:1];

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			rd_q        <= 1'b0;
			latch_valid <= 1'b0;
			latch       <= '0;
		end else begin
			rd_q <= rd;
			if (!adpcm_en) begin
				latch_valid <= 1'b0;
			end else if (rd_rise) begin
				latch       <= masked;
				latch_valid <= 1'b1;
			end
		end
	end

	neo_sdram_req_port #(.payload_t(rd_req_t)) u_port (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.issue      (issue),
		.payload_in (next_req),
		.ack        (ack),
		.req        (req),
		.payload    (payload),
		.busy       (busy)
	);

	assign ready = !busy;

	always_comb begin
		if (!adpcm_en) begin
			data = `NEO_SILENT_SAMPLE;
		end else begin
			case (latch[1:0])
				2'd0: data = q[7:0];
				2'd1: data = q[15:8];
				2'd2: data = q[23:16];
				default: data = q[31:24];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- neo_cart_loader.sv
`default_nettype none

module neo_cart_loader (
	input  wire logic                   CLK_48M,
	input  wire logic                   pll_locked,
	input  wire neo_loader_pkg::ioctl_t ioctl,

	output logic                        port1_req,
	output neo_loader_pkg::wr_req_t     port1_payload,
	input  wire logic                   port1_ack,
	output logic                        port2_req,
	output neo_loader_pkg::wr_req_t     port2_payload,
	input  wire logic                   port2_ack,

	output logic                        samplea_req,
	output neo_loader_pkg::rd_req_t     samplea_payload,
	input  wire logic                   samplea_ack,
	input  wire logic [31:0]            samplea_q,
	output logic                        sampleb_req,
	output neo_loader_pkg::rd_req_t     sampleb_payload,
	input  wire logic                   sampleb_ack,
	input  wire logic [31:0]            sampleb_q,

	input  wire logic                   adpcma_rd,
	input  wire logic [3:0]             adpcma_bank,
	input  wire logic [19:0]            adpcma_addr,
	output logic [7:0]                  adpcma_data,
	output logic                        adpcma_ready,
	input  wire logic                   adpcmb_rd,
	input  wire logic [23:0]            adpcmb_addr,
	output logic [7:0]                  adpcmb_data,
	output logic                        adpcmb_ready
);
	import neo_loader_pkg::*;

	rom_region_e region;
	logic        byte_wanted;
	rom_sizes_t  sizes;
	rom_masks_t  masks;
	logic [25:0] pcm_base;
	logic        pcm_merged;
	logic        adpcm_en;
	logic [23:0] b_mask;
	logic [25:0] b_base;

	neo_header_parser u_parser (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl       (ioctl),
		.region      (region),
		.byte_wanted (byte_wanted),
		.sizes       (sizes),
		.masks       (masks),
		.pcm_base    (pcm_base),
		.pcm_merged  (pcm_merged),
		.adpcm_en    (adpcm_en)
	);

	neo_dl_fifo u_dl_fifo (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl       (ioctl),
		.region      (region),
		.byte_wanted (byte_wanted),
		.sizes       (sizes),
		.p1_ack      (port1_ack),
		.p2_ack      (port2_ack),
		.p1_req      (port1_req),
		.p1_payload  (port1_payload),
		.p2_req      (port2_req),
		.p2_payload  (port2_payload)
	);

	// Merged carts keep ADPCM-B inside the V1 image
	assign b_mask = pcm_merged ? masks.v1_mask : masks.v2_mask;
	assign b_base = pcm_merged ? pcm_base : pcm_base + sizes.v1[25:0];

	neo_adpcm_fetch u_fetch_a (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.rd         (adpcma_rd),
		.addr       ({adpcma_bank, adpcma_addr}),
		.mask       (masks.v1_mask),
		.base       (pcm_base),
		.adpcm_en   (adpcm_en),
		.ack        (samplea_ack),
		.q          (samplea_q),
		.req        (samplea_req),
		.payload    (samplea_payload),
		.data       (adpcma_data),
		.ready      (adpcma_ready)
	);

	neo_adpcm_fetch u_fetch_b (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.rd         (adpcmb_rd),
		.addr       (adpcmb_addr),
		.mask       (b_mask),
		.base       (b_base),
		.adpcm_en   (adpcm_en),
		.ack        (sampleb_ack),
		.q          (sampleb_q),
		.req        (sampleb_req),
		.payload    (sampleb_payload),
		.data       (adpcmb_data),
		.ready      (adpcmb_ready)
	);

endmodule

`default_nettype wire

//--- neo_dl_fifo.sv
`include "neo_loader_defs.svh"
`default_nettype none

module neo_dl_fifo (
	input  wire logic                     CLK_48M,
	input  wire logic                     pll_locked,
	input  wire neo_loader_pkg::ioctl_t   ioctl,
	input  wire neo_loader_pkg::rom_region_e region,
	input  wire logic                     byte_wanted,
	input  wire neo_loader_pkg::rom_sizes_t sizes,
	input  wire logic                     p1_ack,
	input  wire logic                     p2_ack,
	output logic                          p1_req,
	output neo_loader_pkg::wr_req_t       p1_payload,
	output logic                          p2_req,
	output neo_loader_pkg::wr_req_t       p2_payload
);
	import neo_loader_pkg::*;

	logic [1:0][7:0] page_mem [128]; // Two pages of 64 words
	logic            wr_page;
	logic            rd_page;
	logic [6:0]      src_pos;
	logic [6:0]      wr_pos;
	logic            page_end;
	logic            new_dl;
	logic            flush_active;
	logic [5:0]      word_idx;
	rom_region_e     flush_region;
	logic [26:0]     flush_base;
	logic [26:0]     word_off;
	logic [15:0]     word_data;
	logic            to_p1;
	logic [`NEO_ADDR_W-1:0] p1_byte;
	logic [31:0]     p2_byte;
	logic            p1_busy;
	logic            p2_busy;
	logic            p1_issue;
	logic            p2_issue;
	wr_req_t         p1_next;
	wr_req_t         p2_next;

	assign src_pos = ioctl.addr[6:0];

	// Tile reordering for FIX and sprite data
	always_comb begin
		case (region)
			REG_S:   wr_pos = {src_pos[6:5], src_pos[2:0], ~src_pos[4], src_pos[3]};
			REG_C:   wr_pos = {src_pos[5:2], ~src_pos[6], src_pos[0], src_pos[1]};
			default: wr_pos = src_pos;
		endcase
	end

	assign page_end = byte_wanted && src_pos == 7'(`NEO_PAGE_BYTES - 1);

	always_ff @(posedge CLK_48M) begin
		if (byte_wanted)
			page_mem[{wr_page, wr_pos[6:1]}][wr_pos[0]] <= ioctl.dout;
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			wr_page      <= 1'b0;
			rd_page      <= 1'b1;
			new_dl       <= 1'b1;
			flush_active <= 1'b0;
			word_idx     <= '0;
			flush_region <= REG_DONE;
			flush_base   <= '0;
		end else begin
			if (ioctl.downl && ioctl.wr && ioctl.addr < `NEO_HDR_BYTES)
				new_dl <= 1'b1;
			if (page_end) begin
				wr_page      <= !wr_page;
				rd_page      <= wr_page;
				flush_active <= 1'b1;
				word_idx     <= '0;
				flush_region <= region;
				new_dl       <= 1'b0;
				// Offset restarts with each region
				if (!new_dl && region == flush_region)
					flush_base <= flush_base + 27'(`NEO_PAGE_BYTES);
				else
					flush_base <= '0;
			end else if (p1_issue || p2_issue) begin
				word_idx <= word_idx + 6'd1;
				if (&word_idx)
					flush_active <= 1'b0;
			end
		end
	end

	assign word_off  = flush_base + 27'({word_idx, 1'b0});
	assign word_data = page_mem[{rd_page, word_idx}];
	assign to_p1     = flush_region inside {REG_P, REG_S, REG_M};

	always_comb begin
		case (flush_region)
			REG_S:   p1_byte = `NEO_FIX_BASE + word_off[23:0];
			REG_M:   p1_byte = `NEO_MROM_BASE + word_off[23:0];
			default: p1_byte = word_off[23:0];
		endcase
	end

	// Banks 0-2 hold C, then V1, then V2
	always_comb begin
		case (flush_region)
			REG_V1:  p2_byte = sizes.c + {5'd0, word_off};
			REG_V2:  p2_byte = sizes.c + sizes.v1 + {5'd0, word_off};
			default: p2_byte = {5'd0, word_off};
		endcase
	end

	assign p1_next  = '{addr: {2'b00, p1_byte[23:1]}, data: word_data};
	assign p2_next  = '{addr: p2_byte[25:1], data: word_data};
	assign p1_issue = flush_active && to_p1 && !p1_busy;
	assign p2_issue = flush_active && !to_p1 && !p2_busy;

	neo_sdram_req_port #(.payload_t(wr_req_t)) u_port1 (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.issue      (p1_issue),
		.payload_in (p1_next),
		.ack        (p1_ack),
		.req        (p1_req),
		.payload    (p1_payload),
		.busy       (p1_busy)
	);

	neo_sdram_req_port #(.payload_t(wr_req_t)) u_port2 (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.issue      (p2_issue),
		.payload_in (p2_next),
		.ack        (p2_ack),
		.req        (p2_req),
		.payload    (p2_payload),
		.busy       (p2_busy)
	);

	// Host pacing must let a page drain before the next one fills
	assert property (@(posedge CLK_48M) disable iff (!pll_locked) page_end |-> !flush_active)
		else $error("page switch while previous page still flushing");

endmodule

`default_nettype wire

//--- neo_header_parser.sv
`include "neo_loader_defs.svh"
`default_nettype none

module neo_header_parser (
	input  wire logic                     CLK_48M,
	input  wire logic                     pll_locked,
	input  wire neo_loader_pkg::ioctl_t   ioctl,
	output neo_loader_pkg::rom_region_e   region,
	output logic                          byte_wanted,
	output neo_loader_pkg::rom_sizes_t    sizes,
	output neo_loader_pkg::rom_masks_t    masks,
	output logic [25:0]                   pcm_base,
	output logic                          pcm_merged,
	output logic                          adpcm_en
);
	import neo_loader_pkg::*;

	logic [26:0] offset;
	logic        cart_write;
	logic        in_header;
	logic        skip_adpcm;
	logic [31:0] cur_size;

	function automatic logic [31:0] size_of(input logic [2:0] r, input rom_sizes_t s);
		case (r)
			REG_P:   return s.p;
			REG_S:   return s.s;
			REG_M:   return s.m;
			REG_V1:  return s.v1;
			REG_V2:  return s.v2;
			REG_C:   return s.c;
			default: return '0;
		endcase
	endfunction

	// First region at or after start with a nonzero size
	function automatic rom_region_e next_region(input logic [2:0] start, input rom_sizes_t s);
		rom_region_e r;
		r = REG_DONE;
		for (int i = 5; i >= 0; i--) begin
			if (i >= start && size_of(3'(i), s) != 0)
				r = rom_region_e'(i);
		end
		return r;
	endfunction

	// Round up to a power of two, minus one
	function automatic logic [23:0] ceil_mask(input logic [31:0] size);
		logic [31:0] m;
		m = size - 32'd1;
		m = m | (m >> 1);
		m = m | (m >> 2);
		m = m | (m >> 4);
		m = m | (m >> 8);
		m = m | (m >> 16);
		if (size == 0)
			m = '0;
		return m[23:0];
	endfunction

	assign cart_write = ioctl.downl && (ioctl.index == 8'd1 || ioctl.index == 8'd2);
	assign in_header  = ioctl.addr < `NEO_HDR_BYTES;
	assign skip_adpcm = ioctl.index == 8'd2;
	assign cur_size   = size_of(region, sizes);

	// Doubles as the buffer's write strobe
	assign byte_wanted = cart_write && ioctl.wr && !in_header && region != REG_DONE &&
		!(skip_adpcm && (region == REG_V1 || region == REG_V2));

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			sizes      <= '0;
			region     <= REG_DONE;
			offset     <= '0;
			pcm_merged <= 1'b0;
			adpcm_en   <= 1'b0;
		end else if (cart_write && ioctl.wr) begin
			if (in_header) begin
				if (ioctl.addr >= `NEO_SIZE_FIRST && ioctl.addr <= `NEO_SIZE_LAST)
					sizes <= {ioctl.dout, sizes[191:8]};
				if (ioctl.addr == `NEO_HDR_BYTES - 1) begin
					region     <= next_region(3'd0, sizes);
					offset     <= '0;
					pcm_merged <= sizes.v2 == 0; // V1 and V2 share one image
					adpcm_en   <= !skip_adpcm;
				end
			end else if (region != REG_DONE) begin
				if ({5'd0, offset} + 32'd1 == cur_size) begin
					region <= next_region(3'(region + 3'd1), sizes);
					offset <= '0;
				end else begin
					offset <= offset + 27'd1;
				end
			end
		end
	end

	always_comb begin
		masks.v1_mask = ceil_mask(sizes.v1);
		masks.v2_mask = ceil_mask(sizes.v2);
	end

	assign pcm_base = sizes.c[25:0]; // Samples sit after the sprites

endmodule

`default_nettype wire

//--- neo_loader_defs.svh
`ifndef NEO_LOADER_DEFS_SVH
`define NEO_LOADER_DEFS_SVH

// .NEO header layout
`define NEO_HDR_BYTES 4096

// Six little-endian 32-bit sizes: P, S, M, V1, V2, C
`define NEO_SIZE_FIRST 4
`define NEO_SIZE_LAST 27

// Download buffer page
`define NEO_PAGE_BYTES 128

// Bank 3 byte bases
`define NEO_FIX_BASE 24'hE00000
`define NEO_MROM_BASE 24'hF00000

// Returned by a disabled sample fetch
`define NEO_SILENT_SAMPLE 8'h80

// Byte address widths
`define NEO_ADDR_W 24
`define NEO_P2_ADDR_W 26

`endif

//--- neo_loader_pkg.sv
`include "neo_loader_defs.svh"
`default_nettype none

package neo_loader_pkg;

	// Cart regions in file order
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C,
		REG_DONE
	} rom_region_e;

	// Download stream from the host
	typedef struct packed {
		logic        downl;
		logic [7:0]  index;
		logic        wr;    // One cycle per byte
		logic [26:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

	// First header byte ends up in p[7:0]
	typedef struct packed {
		logic [31:0] c;
		logic [31:0] v2;
		logic [31:0] v1;
		logic [31:0] m;
		logic [31:0] s;
		logic [31:0] p;
	} rom_sizes_t;

	typedef struct packed {
		logic [`NEO_ADDR_W-1:0] v1_mask;
		logic [`NEO_ADDR_W-1:0] v2_mask;
	} rom_masks_t;

	// 16-bit word write
	typedef struct packed {
		logic [`NEO_P2_ADDR_W-2:0] addr;
		logic [15:0]               data;
	} wr_req_t;

	// 32-bit sample read, addressed in 16-bit words
	typedef struct packed {
		logic [`NEO_P2_ADDR_W-2:0] addr;
	} rd_req_t;

endpackage

`default_nettype wire

//--- neo_sdram_req_port.sv
`default_nettype none

module neo_sdram_req_port #(
	parameter type payload_t = logic
) (
	input  wire logic      CLK_48M,
	input  wire logic      pll_locked,
	input  wire logic      issue,
	input  wire payload_t  payload_in,
	input  wire logic      ack,
	output logic           req,
	output payload_t       payload,
	output logic           busy
);

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked)
			req <= 1'b0;
		else if (issue)
			req <= !req;
	end

	// Held until ack catches up
	always_ff @(posedge CLK_48M) begin
		if (issue)
			payload <= payload_in;
	end

	assign busy = req != ack;

	// A new request may only follow a completed one
	assert property (@(posedge CLK_48M) disable iff (!pll_locked) issue |-> !busy)
		else $error("request issued before previous ack");

endmodule

`default_nettype wire

//--- tb_neo_cart_loader.sv
`include "neo_loader_defs.svh"
`default_nettype none

module tb_neo_cart_loader;
	timeunit 1ns;
	timeprecision 100ps;
	import neo_loader_pkg::*;

	logic        CLK_48M;
	logic        pll_locked;
	ioctl_t      ioctl;
	logic        port1_req;
	logic        port1_ack;
	wr_req_t     port1_payload;
	logic        port2_req;
	logic        port2_ack;
	wr_req_t     port2_payload;
	logic        samplea_req;
	logic        samplea_ack;
	rd_req_t     samplea_payload;
	logic [31:0] samplea_q;
	logic        sampleb_req;
	logic        sampleb_ack;
	rd_req_t     sampleb_payload;
	logic [31:0] sampleb_q;
	logic        adpcma_rd;
	logic [3:0]  adpcma_bank;
	logic [19:0] adpcma_addr;
	logic [7:0]  adpcma_data;
	logic        adpcma_ready;
	logic        adpcmb_rd;
	logic [23:0] adpcmb_addr;
	logic [7:0]  adpcmb_data;
	logic        adpcmb_ready;

	integer      seed;
	int          errors;
	int          checks;
	int          cycles;
	int          cycle_limit;
	string       test_name;
	int          cur_index;
	int          sz [6];       // P, S, M, V1, V2, C
	logic [15:0] exp_p1 [int];
	logic [15:0] exp_p2 [int];
	bit          last_valid [2];
	logic [21:0] last_word [2];
	logic [31:0] last_q [2];

	neo_cart_loader UUT (
		.CLK_48M         (CLK_48M),
		.pll_locked      (pll_locked),
		.ioctl           (ioctl),
		.port1_req       (port1_req),
		.port1_payload   (port1_payload),
		.port1_ack       (port1_ack),
		.port2_req       (port2_req),
		.port2_payload   (port2_payload),
		.port2_ack       (port2_ack),
		.samplea_req     (samplea_req),
		.samplea_payload (samplea_payload),
		.samplea_ack     (samplea_ack),
		.samplea_q       (samplea_q),
		.sampleb_req     (sampleb_req),
		.sampleb_payload (sampleb_payload),
		.sampleb_ack     (sampleb_ack),
		.sampleb_q       (sampleb_q),
		.adpcma_rd       (adpcma_rd),
		.adpcma_bank     (adpcma_bank),
		.adpcma_addr     (adpcma_addr),
		.adpcma_data     (adpcma_data),
		.adpcma_ready    (adpcma_ready),
		.adpcmb_rd       (adpcmb_rd),
		.adpcmb_addr     (adpcmb_addr),
		.adpcmb_data     (adpcmb_data),
		.adpcmb_ready    (adpcmb_ready)
	);

	tb_neo_sdram_model #(.WRITE_PORT(1'b1)) mem_p1 (
		CLK_48M, pll_locked, port1_req, port1_payload.addr, port1_payload.data, port1_ack, );
	tb_neo_sdram_model #(.WRITE_PORT(1'b1)) mem_p2 (
		CLK_48M, pll_locked, port2_req, port2_payload.addr, port2_payload.data, port2_ack, );
	tb_neo_sdram_model #(.WRITE_PORT(1'b0)) mem_sa (
		CLK_48M, pll_locked, samplea_req, samplea_payload.addr, 16'h0000, samplea_ack, samplea_q);
	tb_neo_sdram_model #(.WRITE_PORT(1'b0)) mem_sb (
		CLK_48M, pll_locked, sampleb_req, sampleb_payload.addr, 16'h0000, sampleb_ack, sampleb_q);

	initial CLK_48M = 1'b0;
	always #2 CLK_48M = ~CLK_48M;

	always @(posedge CLK_48M) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_word(input string what, input wr_req_t exp, input wr_req_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_sample(input string what, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_req(input string what, input rd_req_t exp, input rd_req_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic next_cycle();
		@(posedge CLK_48M);
		#0.5;
	endtask

	// Sample ROM contents, unique per word address
	function automatic logic [15:0] fill_word(input int a);
		return 16'((a * 32'h9E37) >> 3) ^ 16'(a);
	endfunction

	function automatic logic [23:0] pow2_mask(input int size);
		int m;
		m = 1;
		while (m < size)
			m = m * 2;
		return (size == 0) ? 24'd0 : 24'(m - 1);
	endfunction

	// Page position of a byte after FIX or sprite tile reordering
	function automatic int tile_pos(input rom_region_e r, input logic [6:0] s);
		logic [6:0] p;
		p = s;
		if (r == REG_S) begin
			p[4] = s[2];
			p[3] = s[1];
			p[2] = s[0];
			p[1] = ~s[4];
			p[0] = s[3];
		end else if (r == REG_C) begin
			p[6] = s[5];
			p[5] = s[4];
			p[4] = s[3];
			p[3] = s[2];
			p[2] = ~s[6];
			p[1] = s[0];
			p[0] = s[1];
		end
		return int'(p);
	endfunction

	task automatic expect_byte(input rom_region_e r, input int off, input logic [7:0] d);
		int          dest;
		int          baddr;
		logic [15:0] v;
		dest = (off / 128) * 128 + tile_pos(r, 7'(off % 128));
		case (r)
			REG_S:   baddr = `NEO_FIX_BASE + dest;
			REG_M:   baddr = `NEO_MROM_BASE + dest;
			REG_V1:  baddr = sz[REG_C] + dest;
			REG_V2:  baddr = sz[REG_C] + sz[REG_V1] + dest;
			default: baddr = dest;
		endcase
		if (r inside {REG_P, REG_S, REG_M})
			v = exp_p1.exists(baddr / 2) ? exp_p1[baddr / 2] : 16'h0000;
		else
			v = exp_p2.exists(baddr / 2) ? exp_p2[baddr / 2] : 16'h0000;
		if (baddr % 2)
			v[15:8] = d;
		else
			v[7:0] = d;
		if (r inside {REG_P, REG_S, REG_M})
			exp_p1[baddr / 2] = v;
		else
			exp_p2[baddr / 2] = v;
	endtask

	task automatic send_byte(input int a, input logic [7:0] d);
		int gap;
		gap = 2 + ($unsigned($random(seed)) % 2);
		next_cycle();
		ioctl.addr = 27'(a);
		ioctl.dout = d;
		ioctl.wr   = 1'b1;
		next_cycle();
		ioctl.wr = 1'b0;
		repeat (gap) next_cycle();
	endtask

	task automatic compare_images();
		wr_req_t exp_w;
		wr_req_t act_w;
		if (mem_p1.write_count() != exp_p1.num())
			report_failure($sformatf("port 1 stored %0d words instead of %0d",
				mem_p1.write_count(), exp_p1.num()));
		if (mem_p2.write_count() != exp_p2.num())
			report_failure($sformatf("port 2 stored %0d words instead of %0d",
				mem_p2.write_count(), exp_p2.num()));
		foreach (exp_p1[a]) begin
			exp_w = '{addr: 25'(a), data: exp_p1[a]};
			act_w = '{addr: 25'(a), data: mem_p1.get_word(a)};
			if (!mem_p1.has_word(a))
				report_failure($sformatf("port 1 word %h was never written", a));
			else
				check_word("port1 word", exp_w, act_w);
		end
		foreach (exp_p2[a]) begin
			exp_w = '{addr: 25'(a), data: exp_p2[a]};
			act_w = '{addr: 25'(a), data: mem_p2.get_word(a)};
			if (!mem_p2.has_word(a))
				report_failure($sformatf("port 2 word %h was never written", a));
			else
				check_word("port2 word", exp_w, act_w);
		end
	endtask

	task automatic adpcm_read(input bit ch, input logic [23:0] a);
		logic [23:0] mask;
		int          base;
		logic [23:0] m;
		int          exp_byte;
		rd_req_t     exp_req;
		logic [31:0] wd;
		logic [7:0]  exp_data;
		logic        req_before;
		logic        req_now;
		bit          en;
		bit          same;
		int          waited;
		en = cur_index == 1;
		if (!ch || sz[REG_V2] == 0) begin
			mask = pow2_mask(sz[REG_V1]);
			base = sz[REG_C];
		end else begin
			mask = pow2_mask(sz[REG_V2]);
			base = sz[REG_C] + sz[REG_V1];
		end
		m = a & mask;
		exp_byte = base + int'(m & ~24'd3);
		exp_req.addr = 25'(exp_byte / 2);
		wd = {fill_word(exp_byte / 2 + 1), fill_word(exp_byte / 2)};
		same = last_valid[ch] && last_word[ch] == m[23:2];
		req_before = ch ? sampleb_req : samplea_req;
		if (ch) begin
			adpcmb_rd   = 1'b1;
			adpcmb_addr = a;
		end else begin
			adpcma_rd   = 1'b1;
			adpcma_bank = a[23:20];
			adpcma_addr = a[19:0];
		end
		next_cycle();
		req_now = ch ? sampleb_req : samplea_req;
		if (en && !same) begin
			if (req_now == req_before)
				report_failure($sformatf("channel %0d issued no request for a new word", ch));
			check_req(ch ? "sampleb req" : "samplea req", exp_req,
				ch ? sampleb_payload : samplea_payload);
			last_q[ch] = wd;
		end else if (req_now != req_before) begin
			report_failure($sformatf("channel %0d issued an unexpected request", ch));
		end
		if (en) begin
			last_valid[ch] = 1'b1;
			last_word[ch]  = m[23:2];
		end
		waited = 0;
		while (!(ch ? adpcmb_ready : adpcma_ready) && waited < 20) begin
			next_cycle();
			waited++;
		end
		if (waited >= 20)
			report_failure($sformatf("channel %0d never became ready", ch));
		exp_data = en ? last_q[ch][8 * m[1:0] +: 8] : `NEO_SILENT_SAMPLE;
		check_sample(ch ? "adpcmb data" : "adpcma data", exp_data,
			ch ? adpcmb_data : adpcma_data);
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
		next_cycle();
	endtask

	task automatic adpcm_reads();
		logic [23:0] a;
		logic [23:0] prev [2];
		bit          ch;
		for (int k = 0; k < 24; k++) begin
			ch = k[0];
			if (k % 6 >= 4)
				a = prev[ch] ^ 24'd1; // Same word again
			else
				a = 24'($random(seed));
			prev[ch] = a;
			adpcm_read(ch, a);
		end
	endtask

	// Download stream with no download running must stay invisible
	task automatic idle_noise();
		test_name = "reset_idle";
		for (int k = 0; k < 40; k++) begin
			next_cycle();
			ioctl.downl = 1'b0;
			ioctl.index = 8'($random(seed));
			ioctl.wr    = k[0];
			ioctl.addr  = 27'($random(seed));
			ioctl.dout  = 8'($random(seed));
			adpcma_rd   = k[2];
			adpcmb_rd   = k[3];
			adpcma_addr = 20'($random(seed));
			adpcmb_addr = 24'($random(seed));
			if (port1_req || port2_req || samplea_req || sampleb_req)
				report_failure("a request toggled before any download");
			if (!adpcma_ready || !adpcmb_ready)
				report_failure("ready dropped before any download");
			check_sample("adpcma idle data", `NEO_SILENT_SAMPLE, adpcma_data);
			check_sample("adpcmb idle data", `NEO_SILENT_SAMPLE, adpcmb_data);
		end
		ioctl     = '0;
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
		next_cycle();
	endtask

	task automatic run_cart(input int t, input int idx, input bit no_v2);
		int          total;
		int          pos;
		logic [7:0]  d;
		rom_region_e r;
		test_name = $sformatf("cart%0d_index%0d", t, idx);
		cur_index = idx;
		total = 0;
		for (int k = 0; k < 6; k++) begin
			sz[k] = 128 * ($unsigned($random(seed)) % 5);
			if (no_v2 && k == REG_V2)
				sz[k] = 0;
			total += sz[k];
		end
		cycle_limit += 8 * (`NEO_HDR_BYTES + total);
		if (idx != 1)
			last_valid = '{1'b0, 1'b0};
		exp_p1.delete();
		exp_p2.delete();
		mem_p1.clear_words();
		mem_p2.clear_words();
		ioctl.downl = 1'b1;
		ioctl.index = 8'(idx);
		for (int i = 0; i < `NEO_HDR_BYTES; i++) begin
			if (i >= `NEO_SIZE_FIRST && i <= `NEO_SIZE_LAST)
				d = 8'(sz[(i - 4) / 4] >> (8 * ((i - 4) % 4))); // Little endian
			else
				d = 8'($random(seed));
			send_byte(i, d);
		end
		pos = `NEO_HDR_BYTES;
		for (int k = 0; k < 6; k++) begin
			r = rom_region_e'(k);
			for (int off = 0; off < sz[k]; off++) begin
				d = 8'($random(seed));
				send_byte(pos, d);
				if (!(idx == 2 && (r == REG_V1 || r == REG_V2)))
					expect_byte(r, off, d);
				pos++;
			end
		end
		ioctl.downl = 1'b0;
		// Last page drains after the final byte
		while (mem_p1.write_count() + mem_p2.write_count() < exp_p1.num() + exp_p2.num())
			next_cycle();
		repeat (20) next_cycle();
		compare_images();
		adpcm_reads();
	endtask

	initial begin
		seed        = 49;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		cycle_limit = 2000;
		cur_index   = 0;
		last_valid  = '{1'b0, 1'b0};
		pll_locked  = 1'b0;
		ioctl       = '0;
		adpcma_rd   = 1'b0;
		adpcma_bank = '0;
		adpcma_addr = '0;
		adpcmb_rd   = 1'b0;
		adpcmb_addr = '0;
		for (int i = 0; i < 1024; i++) begin
			mem_sa.set_rom(i, fill_word(i));
			mem_sb.set_rom(i, fill_word(i));
		end
		repeat (5) @(posedge CLK_48M);
		#0.5;
		pll_locked = 1'b1;
		idle_noise();
		run_cart(0, 1, 1'b0);
		run_cart(1, 1, 1'b1);
		run_cart(2, 2, 1'b0);
		run_cart(3, 1, 1'b0);
		run_cart(4, 2, 1'b1);
		run_cart(5, 1, 1'b0);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_neo_sdram_model.sv
`default_nettype none

module tb_neo_sdram_model #(
	parameter bit WRITE_PORT = 1'b1
) (
	input  wire logic        CLK_48M,
	input  wire logic        pll_locked,
	input  wire logic        req,
	input  wire logic [24:0] addr,
	input  wire logic [15:0] wdata,
	output logic             ack,
	output logic [31:0]      q
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] words [int]; // Keyed by word address
	logic [15:0] rom [1024];  // Sample words
	int          writes;
	integer      seed;
	logic        pending;
	logic [1:0]  delay;

	initial begin
		seed    = 49;
		writes  = 0;
		ack     = 1'b0;
		q       = '0;
		pending = 1'b0;
		delay   = '0;
	end

	function automatic logic [15:0] rom_word(input int a);
		if (a >= 0 && a < 1024)
			return rom[a];
		return 16'h0000;
	endfunction

	function automatic bit has_word(input int a);
		return words.exists(a) != 0;
	endfunction

	function automatic logic [15:0] get_word(input int a);
		return words[a];
	endfunction

	function automatic int write_count();
		return writes;
	endfunction

	task automatic clear_words();
		words.delete();
		writes = 0;
	endtask

	task automatic set_rom(input int a, input logic [15:0] v);
		rom[a] = v;
	endtask

	// Ack 1 to 3 cycles after a new request shows up
	always @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			ack     <= 1'b0;
			pending <= 1'b0;
			delay   <= '0;
			q       <= '0;
		end else if (!pending) begin
			if (req != ack) begin
				pending <= 1'b1;
				delay   <= 2'($unsigned($random(seed)) % 3);
			end
		end else if (delay != 0) begin
			delay <= delay - 2'd1;
		end else begin
			pending <= 1'b0;
			ack     <= req;
			if (WRITE_PORT) begin
				words[int'(addr)] = wdata;
				writes = writes + 1;
			end else begin
				q <= {rom_word(int'(addr) + 1), rom_word(int'(addr))};
			end
		end
	end

endmodule

`default_nettype wire
